/* include/bp_params.svh */
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// fetch and resolve PC width
`define BP_WORD_SIZE 16

// direct-mapped index, low bits of the PC
`define BP_IDX_SIZE 4

// tag is whatever is left above the index
`define BP_TAG_SIZE (`BP_WORD_SIZE - `BP_IDX_SIZE)

// number of buffer entries and per-index counters
`define BP_ENTRIES (1 << `BP_IDX_SIZE)

// end of program memory, sequential fetch stalls here
`define BP_PC_LIMIT 16'h00c6

`endif

/* verilog/bp_pkg.sv */
`default_nettype none

`include "bp_params.svh"

package bp_pkg;

	// tag / index split of a PC
	typedef struct packed {
		logic [`BP_TAG_SIZE-1:0] tag;
		logic [`BP_IDX_SIZE-1:0] idx;
	} pc_fields_t;

	// same word, seen whole or split for table access
	typedef union packed {
		logic [`BP_WORD_SIZE-1:0] word;
		pc_fields_t               f;
	} pc_u;

	// report from the branch resolve stage
	typedef struct packed {
		logic                     valid;    // one-cycle strobe per branch or jump
		pc_u                      pc;       // PC of the resolved branch
		logic [`BP_WORD_SIZE-1:0] taken_pc; // target if taken
		logic [`BP_WORD_SIZE-1:0] next_pc;  // where it really went
	} resolve_t;

	// one BTB line
	typedef struct packed {
		logic                     valid;
		logic [`BP_TAG_SIZE-1:0]  tag;
		logic [`BP_WORD_SIZE-1:0] target;
	} btb_entry_t;

	// direction policy, picked at run time
	typedef enum logic [2:0] {
		POL_NOT_TAKEN  = 3'd0,
		POL_BTB_TAKEN  = 3'd1,
		POL_GLOBAL_SAT = 3'd2,
		POL_GLOBAL_HYS = 3'd3,
		POL_LOCAL_SAT  = 3'd4,
		POL_LOCAL_HYS  = 3'd5
	} policy_t;

endpackage

`default_nettype wire

/* verilog/branch_target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// direct-mapped BTB with combinational lookup and one-edge write
module branch_target_buffer
	import bp_pkg::*;
(
	input  wire logic                     clk,
	input  wire logic                     reset_n,
	input  wire pc_u                      pc,
	input  wire resolve_t                 resolve,
	output logic                          hit,
	output logic [`BP_WORD_SIZE-1:0]      target
);

	btb_entry_t entries [`BP_ENTRIES];
	btb_entry_t rd_entry; // line at the fetch index
	btb_entry_t wr_entry; // line built from the resolve report

	// lookup on the fetch PC
	assign rd_entry = entries[pc.f.idx];
	assign hit      = rd_entry.valid && (rd_entry.tag == pc.f.tag);
	assign target   = rd_entry.target;

	// every resolved branch is recorded whether taken or not
	assign wr_entry = '{
		valid:  1'b1,
		tag:    resolve.pc.f.tag,
		target: resolve.taken_pc
	};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				entries[i].valid <= 1'b0; // tag and target left stale
			end
		end else if (resolve.valid) begin
			entries[resolve.pc.f.idx] <= wr_entry;
		end
	end

	// an X on the resolve PC would smear across an unknown entry
	a_resolve_pc_known: assert property (
		@(posedge clk) disable iff (!reset_n)
		resolve.valid |-> !$isunknown(resolve.pc)
	) else $error("resolve pc has unknown bits while valid is high");

endmodule

`default_nettype wire

/* verilog/direction_counters.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// global and per-index 2-bit direction counters
module direction_counters
	import bp_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    reset_n,
	input  wire pc_u     pc,
	input  wire resolve_t resolve,
	input  wire policy_t policy,
	output logic         predict_taken
);

	logic       taken;              // outcome of the resolved branch
	logic [1:0] glb_sat;
	logic [1:0] glb_hys;
	logic [1:0] loc_sat [`BP_ENTRIES];
	logic [1:0] loc_hys [`BP_ENTRIES];
	logic [1:0] fetch_loc_sat;
	logic [1:0] fetch_loc_hys;

	// plain up/down counter, clamps at both ends
	function automatic logic [1:0] sat_next(input logic [1:0] cnt, input logic tkn);
		logic [1:0] nxt;
		if (tkn) begin
			nxt = (cnt == 2'd3) ? cnt : cnt + 2'd1;
		end else begin
			nxt = (cnt == 2'd0) ? cnt : cnt - 2'd1;
		end
		return nxt;
	endfunction

	// hysteresis counter
	// weak states fall straight to the strong state of the new direction
	function automatic logic [1:0] hys_next(input logic [1:0] cnt, input logic tkn);
		logic [1:0] nxt;
		if (tkn) begin
			case (cnt)
				2'd0:    nxt = 2'd1;
				default: nxt = 2'd3; // 1, 2 and 3 all land on strong taken
			endcase
		end else begin
			case (cnt)
				2'd3:    nxt = 2'd2;
				default: nxt = 2'd0;
			endcase
		end
		return nxt;
	endfunction

	// branch went to its taken target
	assign taken = (resolve.next_pc == resolve.taken_pc);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			glb_sat <= 2'd0;
			glb_hys <= 2'd0;
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				loc_sat[i] <= 2'd0;
				loc_hys[i] <= 2'd0;
			end
		end else if (resolve.valid) begin
			glb_sat <= sat_next(glb_sat, taken);
			glb_hys <= hys_next(glb_hys, taken);
			loc_sat[resolve.pc.f.idx] <= sat_next(loc_sat[resolve.pc.f.idx], taken);
			loc_hys[resolve.pc.f.idx] <= hys_next(loc_hys[resolve.pc.f.idx], taken);
		end
	end

	// per-index state for the current fetch
	assign fetch_loc_sat = loc_sat[pc.f.idx];
	assign fetch_loc_hys = loc_hys[pc.f.idx];

	// upper bit set means 2 or 3, i.e. predict taken
	always_comb begin
		case (policy)
			POL_NOT_TAKEN:  predict_taken = 1'b0;
			POL_BTB_TAKEN:  predict_taken = 1'b1;
			POL_GLOBAL_SAT: predict_taken = glb_sat[1];
			POL_GLOBAL_HYS: predict_taken = glb_hys[1];
			POL_LOCAL_SAT:  predict_taken = fetch_loc_sat[1];
			POL_LOCAL_HYS:  predict_taken = fetch_loc_hys[1];
			default:        predict_taken = 1'b0;
		endcase
	end

	a_policy_legal: assert property (
		@(posedge clk)
		reset_n |-> policy inside {POL_NOT_TAKEN, POL_BTB_TAKEN, POL_GLOBAL_SAT,
			POL_GLOBAL_HYS, POL_LOCAL_SAT, POL_LOCAL_HYS}
	) else $error("illegal policy value %0d", policy);

endmodule

`default_nettype wire

/* verilog/next_pc_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// next fetch PC: flush, then predicted target, then sequential
module next_pc_select (
	input  wire logic                     clk, // assertion sampling only
	input  wire logic [`BP_WORD_SIZE-1:0] pc,
	input  wire logic                     flush,
	input  wire logic [`BP_WORD_SIZE-1:0] flush_pc,
	input  wire logic                     hit,
	input  wire logic [`BP_WORD_SIZE-1:0] target,
	input  wire logic                     predict_taken,
	output logic [`BP_WORD_SIZE-1:0]      next_pc
);

	logic [`BP_WORD_SIZE-1:0] seq_pc;
	logic                     use_target;

	// fetch parks at the end of program memory
	assign seq_pc = (pc < `BP_PC_LIMIT) ? pc + 1'b1 : pc;

	assign use_target = hit && predict_taken;

	always_comb begin
		if (flush) begin
			next_pc = flush_pc; // mispredict, redirect
		end else if (use_target) begin
			next_pc = target;
		end else begin
			next_pc = seq_pc;
		end
	end

	// flush wins over any prediction
	a_flush_redirect: assert property (
		@(posedge clk)
		flush |-> next_pc == flush_pc
	) else $error("next_pc %h does not follow flush_pc %h", next_pc, flush_pc);

	// without a hit fetch only steps forward by one or holds
	// widened so pc + 1 cannot wrap
	a_no_hit_seq: assert property (
		@(posedge clk)
		(!flush && !hit) |-> {1'b0, next_pc} <= {1'b0, pc} + 1'b1
	) else $error("next_pc %h jumps ahead of pc %h without a hit", next_pc, pc);

endmodule

`default_nettype wire

/* verilog/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

// fetch-side branch predictor
module branch_predictor
	import bp_pkg::*;
(
	input  wire logic                     clk,
	input  wire logic                     reset_n,
	input  wire logic [`BP_WORD_SIZE-1:0] pc,
	input  wire logic                     flush,
	input  wire resolve_t                 resolve,
	input  wire policy_t                  policy,
	output logic [`BP_WORD_SIZE-1:0]      next_pc,
	output logic                          hit
);

	pc_u                      fetch_pc; // split view for the tables
	logic [`BP_WORD_SIZE-1:0] target;
	logic                     predict_taken;

	assign fetch_pc.word = pc;

	branch_target_buffer i_btb (
		.clk     (clk),
		.reset_n (reset_n),
		.pc      (fetch_pc),
		.resolve (resolve),
		.hit     (hit),
		.target  (target)
	);

	direction_counters i_dir (
		.clk           (clk),
		.reset_n       (reset_n),
		.pc            (fetch_pc),
		.resolve       (resolve),
		.policy        (policy),
		.predict_taken (predict_taken)
	);

	// the resolve stage's actual next PC is the flush redirect
	next_pc_select i_sel (
		.clk           (clk),
		.pc            (pc),
		.flush         (flush),
		.flush_pc      (resolve.next_pc),
		.hit           (hit),
		.target        (target),
		.predict_taken (predict_taken),
		.next_pc       (next_pc)
	);

endmodule

`default_nettype wire

/* test/bp_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock, 100 ns period
module bp_clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // half period
	end

endmodule

`default_nettype wire

/* test/branch_predictor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module branch_predictor_tb
	import bp_pkg::*;
();

	localparam int sample_delay  = 90;  // ns after the rising edge
	localparam int reset_cycles  = 8;
	localparam int reset_timeout = 20;
	localparam int random_cycles = 300;

	// one cycle of stimulus and the expected response
	typedef struct packed {
		policy_t                  policy;
		logic [`BP_WORD_SIZE-1:0] pc;
		logic                     flush;
		resolve_t                 res;
		logic [`BP_WORD_SIZE-1:0] exp_next_pc;
		logic                     exp_hit;
	} row_t;

	logic                     clk;
	logic                     reset_n;
	logic [`BP_WORD_SIZE-1:0] pc;
	logic                     flush;
	resolve_t                 resolve;
	policy_t                  policy;
	logic [`BP_WORD_SIZE-1:0] next_pc;
	logic                     hit;

	row_t        rows [$];
	logic [31:0] lfsr_state;
	int          check_count;
	int          error_count;
	int          timeout_count;
	bit          released;

	// reference copy of the buffer and counters
	logic                     m_valid   [`BP_ENTRIES];
	logic [`BP_TAG_SIZE-1:0]  m_tag     [`BP_ENTRIES];
	logic [`BP_WORD_SIZE-1:0] m_target  [`BP_ENTRIES];
	logic [1:0]               m_loc_sat [`BP_ENTRIES];
	logic [1:0]               m_loc_hys [`BP_ENTRIES];
	logic [1:0]               m_glb_sat;
	logic [1:0]               m_glb_hys;

	bp_clock_gen i_clk_gen (
		.clk (clk)
	);

	branch_predictor i_dut (
		.clk     (clk),
		.reset_n (reset_n),
		.pc      (pc),
		.flush   (flush),
		.resolve (resolve),
		.policy  (policy),
		.next_pc (next_pc),
		.hit     (hit)
	);

	task automatic check_value(input string name, input logic [`BP_WORD_SIZE-1:0] expected,
		input logic [`BP_WORD_SIZE-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	task automatic draw_pc(output logic [15:0] p);
		logic [15:0] high;
		logic [15:0] bits;
		draw_bits(1, high);
		if (high[0]) begin
			draw_bits(3, bits);
			p = 16'h00c0 + bits; // around the end of program memory
		end else begin
			draw_bits(6, bits);
			p = bits; // four tags over all indexes, plenty of hits
		end
	endtask

	function automatic row_t build_row(input policy_t pol, input logic [15:0] p,
		input logic f, input logic rv, input logic [15:0] rpc, input logic [15:0] rtk,
		input logic [15:0] rnx, input logic [15:0] enx, input logic eh);
		row_t r;
		r.policy       = pol;
		r.pc           = p;
		r.flush        = f;
		r.res.valid    = rv;
		r.res.pc.word  = rpc;
		r.res.taken_pc = rtk;
		r.res.next_pc  = rnx;
		r.exp_next_pc  = enx;
		r.exp_hit      = eh;
		return r;
	endfunction

	task automatic add_row(input policy_t pol, input logic [15:0] p, input logic f,
		input logic rv, input logic [15:0] rpc, input logic [15:0] rtk,
		input logic [15:0] rnx, input logic [15:0] enx, input logic eh);
		rows.push_back(build_row(pol, p, f, rv, rpc, rtk, rnx, enx, eh));
	endtask

	function automatic logic [1:0] sat_step(input logic [1:0] c, input logic tkn);
		if (tkn) begin
			return (c == 2'd3) ? 2'd3 : c + 2'd1;
		end
		return (c == 2'd0) ? 2'd0 : c - 2'd1;
	endfunction

	function automatic logic [1:0] hys_step(input logic [1:0] c, input logic tkn);
		case (c)
			2'd0:    return tkn ? 2'd1 : 2'd0;
			2'd1:    return tkn ? 2'd3 : 2'd0;
			2'd2:    return tkn ? 2'd3 : 2'd0;
			default: return tkn ? 2'd3 : 2'd2;
		endcase
	endfunction

	task automatic reset_model();
		for (int i = 0; i < `BP_ENTRIES; i++) begin
			m_valid[i]   = 1'b0;
			m_tag[i]     = '0;
			m_target[i]  = '0;
			m_loc_sat[i] = 2'd0;
			m_loc_hys[i] = 2'd0;
		end
		m_glb_sat = 2'd0;
		m_glb_hys = 2'd0;
	endtask

	// fill in next_pc and hit from the state before this cycle's edge
	function automatic row_t expect_outputs(input row_t r);
		pc_u  u;
		logic h;
		logic tkn;
		u.word = r.pc;
		h = m_valid[u.f.idx] && (m_tag[u.f.idx] == u.f.tag);
		case (r.policy)
			POL_NOT_TAKEN:  tkn = 1'b0;
			POL_BTB_TAKEN:  tkn = 1'b1;
			POL_GLOBAL_SAT: tkn = (m_glb_sat >= 2'd2);
			POL_GLOBAL_HYS: tkn = (m_glb_hys >= 2'd2);
			POL_LOCAL_SAT:  tkn = (m_loc_sat[u.f.idx] >= 2'd2);
			default:        tkn = (m_loc_hys[u.f.idx] >= 2'd2);
		endcase
		r.exp_hit = h;
		if (r.flush) begin
			r.exp_next_pc = r.res.next_pc;
		end else if (h && tkn) begin
			r.exp_next_pc = m_target[u.f.idx];
		end else if (r.pc < `BP_PC_LIMIT) begin
			r.exp_next_pc = r.pc + 16'd1;
		end else begin
			r.exp_next_pc = r.pc; // parked at end of program
		end
		return r;
	endfunction

	task automatic update_tables(input row_t r);
		logic                    tkn;
		logic [`BP_IDX_SIZE-1:0] i;
		if (r.res.valid) begin
			i   = r.res.pc.f.idx;
			tkn = (r.res.next_pc == r.res.taken_pc);
			m_valid[i]   = 1'b1;
			m_tag[i]     = r.res.pc.f.tag;
			m_target[i]  = r.res.taken_pc;
			m_loc_sat[i] = sat_step(m_loc_sat[i], tkn);
			m_loc_hys[i] = hys_step(m_loc_hys[i], tkn);
			m_glb_sat    = sat_step(m_glb_sat, tkn);
			m_glb_hys    = hys_step(m_glb_hys, tkn);
		end
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk);
		policy  <= r.policy;
		pc      <= r.pc;
		flush   <= r.flush;
		resolve <= r.res;
		#(sample_delay);
		check_value("next_pc", r.exp_next_pc, next_pc);
		check_value("hit", {15'b0, r.exp_hit}, {15'b0, hit});
		update_tables(r); // takes effect at the coming edge
	endtask

	task automatic wait_reset_release(output bit ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < reset_timeout) begin
			@(posedge clk);
			ok = (reset_n === 1'b1);
			cycles++;
		end
		if (!ok) begin
			timeout_count++;
			$display("timeout: reset was not released within %0d cycles", reset_timeout);
		end
	endtask

	task automatic table_phase();
		// policy, pc, flush, resolve valid / pc / taken_pc / next_pc, expected next_pc, hit
		add_row(POL_NOT_TAKEN,  'h0010, 0, 0, 'h0000, 'h0000, 'h0000, 'h0011, 0);
		add_row(POL_BTB_TAKEN,  'h00c5, 0, 0, 'h0000, 'h0000, 'h0000, 'h00c6, 0);
		add_row(POL_BTB_TAKEN,  'h00c6, 0, 0, 'h0000, 'h0000, 'h0000, 'h00c6, 0);
		add_row(POL_GLOBAL_SAT, 'h0100, 0, 0, 'h0000, 'h0000, 'h0000, 'h0100, 0);
		add_row(POL_LOCAL_SAT,  'hffff, 0, 0, 'h0000, 'h0000, 'h0000, 'hffff, 0);
		// flush with an empty buffer
		add_row(POL_NOT_TAKEN,  'h0020, 1, 0, 'h0000, 'h0000, 'h0080, 'h0080, 0);
		add_row(POL_LOCAL_HYS,  'h00c8, 1, 0, 'h0000, 'h0000, 'h0004, 'h0004, 0);
		// fill idx 5 with a not-taken branch, then look it up
		add_row(POL_BTB_TAKEN,  'h0030, 0, 1, 'h0035, 'h0070, 'h0036, 'h0031, 0);
		add_row(POL_BTB_TAKEN,  'h0035, 0, 0, 'h0000, 'h0000, 'h0000, 'h0070, 1);
		add_row(POL_BTB_TAKEN,  'h0045, 0, 0, 'h0000, 'h0000, 'h0000, 'h0046, 0);
		add_row(POL_NOT_TAKEN,  'h0035, 0, 0, 'h0000, 'h0000, 'h0000, 'h0036, 1);
		// same-cycle lookup still sees the old line
		add_row(POL_BTB_TAKEN,  'h0042, 0, 1, 'h0042, 'h0090, 'h0043, 'h0043, 0);
		add_row(POL_BTB_TAKEN,  'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0090, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 1, 0, 'h0000, 'h0000, 'h0011, 'h0011, 1);
		// global saturating, counters all at 0 here
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 1, 'h0042, 'h0090, 'h0090, 'h0043, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 1, 'h0042, 'h0090, 'h0090, 'h0043, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 1, 'h0042, 'h0090, 'h0090, 'h0090, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 1, 'h0042, 'h0090, 'h0043, 'h0090, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 1, 'h0042, 'h0090, 'h0043, 'h0090, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0043, 1);
		// global hysteresis 0 -> 1 -> 3 -> 2 -> 0
		add_row(POL_GLOBAL_HYS, 'h0042, 0, 1, 'h0042, 'h0090, 'h0090, 'h0043, 1);
		add_row(POL_GLOBAL_HYS, 'h0042, 0, 1, 'h0042, 'h0090, 'h0090, 'h0043, 1);
		add_row(POL_GLOBAL_HYS, 'h0042, 0, 1, 'h0042, 'h0090, 'h0043, 'h0090, 1);
		add_row(POL_GLOBAL_HYS, 'h0042, 0, 1, 'h0042, 'h0090, 'h0043, 'h0090, 1);
		add_row(POL_GLOBAL_HYS, 'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0043, 1);
		// train idx 5 only, idx 2 keeps its own state
		add_row(POL_LOCAL_SAT,  'h0035, 0, 1, 'h0035, 'h0070, 'h0070, 'h0036, 1);
		add_row(POL_LOCAL_SAT,  'h0035, 0, 1, 'h0035, 'h0070, 'h0070, 'h0036, 1);
		add_row(POL_LOCAL_SAT,  'h0035, 0, 0, 'h0000, 'h0000, 'h0000, 'h0070, 1);
		add_row(POL_LOCAL_SAT,  'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0043, 1);
		add_row(POL_LOCAL_HYS,  'h0035, 0, 0, 'h0000, 'h0000, 'h0000, 'h0070, 1);
		add_row(POL_LOCAL_HYS,  'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0043, 1);
		add_row(POL_GLOBAL_SAT, 'h0042, 0, 0, 'h0000, 'h0000, 'h0000, 'h0090, 1);
		add_row(POL_LOCAL_HYS,  'h0035, 1, 0, 'h0000, 'h0000, 'h00aa, 'h00aa, 1);
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
	endtask

	task automatic random_phase();
		row_t        r;
		policy_t     pol;
		logic [15:0] v;
		logic [15:0] p;
		logic [15:0] fl;
		logic [15:0] rv;
		logic [15:0] rpc;
		logic [15:0] rtk;
		logic [15:0] tk;
		pol = POL_NOT_TAKEN;
		for (int i = 0; i < random_cycles; i++) begin
			if (i % 25 == 0) begin
				draw_bits(3, v);
				v   = v % 6;
				pol = policy_t'(v[2:0]);
			end
			draw_pc(p);
			draw_bits(3, fl); // flush about one cycle in eight
			draw_bits(1, rv);
			draw_pc(rpc);
			draw_bits(16, rtk);
			draw_bits(1, tk);
			r = build_row(pol, p, (fl == 16'd7), rv[0], rpc, rtk,
				tk[0] ? rtk : rpc + 16'd1, '0, 1'b0);
			apply_row(expect_outputs(r));
		end
	endtask

	initial begin
		lfsr_state    = 32'h7a52;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;
		reset_n       = 1'b0;
		pc            = '0;
		flush         = 1'b0;
		resolve       = '0;
		policy        = POL_NOT_TAKEN;
		reset_model();
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
		end
		reset_n <= 1'b1;
		wait_reset_release(released);
		if (released) begin
			table_phase();
			random_phase();
		end
		$display("%0d checks, %0d mismatches, %0d timeouts", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* branch_predictor.f */
+incdir+include
verilog/bp_pkg.sv
verilog/branch_target_buffer.sv
verilog/direction_counters.sv
verilog/next_pc_select.sv
verilog/branch_predictor.sv
test/bp_clock_gen.sv
test/branch_predictor_tb.sv
